// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define CPU_WORD_WIDTH 8
`define CPU_RESET_IP 8'h00

// whole-byte opcodes
`define CPU_NOP_OPCODE 8'hFE
`define CPU_HLT_OPCODE 8'hFF

// opcode byte fields
`define CPU_OP_MSB 7
`define CPU_OP_LSB 4
`define CPU_DST_MSB 3
`define CPU_DST_LSB 2
`define CPU_SRC_MSB 1
`define CPU_SRC_LSB 0

// operation nibble patterns
`define CPU_OP_MOV 4'b0000
`define CPU_OP_ADD 4'b0001
`define CPU_OP_JMP 4'b1100

// mode codes
`define CPU_MODE_REG_A 2'b00
`define CPU_MODE_ADDR_REG_A 2'b01
`define CPU_MODE_ADDR_IMM 2'b10
`define CPU_MODE_IMM 2'b11

`endif

// File: hdl/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_WIDTH-1:0] word_t;

  typedef enum logic [2:0] {
    MOV,
    ADD,
    JMP,
    NOP,
    HLT
  } opcode_t;

  // IMM as a destination means no write
  typedef enum logic [2:0] {
    REG_A,
    ADDR_REG_A,
    ADDR_IMM,
    IMM,
    UNUSED
  } operand_mode_t;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_READ,
    MEM_WRITE
  } mem_cmd_t;

  typedef struct packed {
    mem_cmd_t cmd;
    word_t    addr;
    word_t    wdata;
  } mem_req_t;

  typedef struct packed {
    opcode_t       op;
    operand_mode_t src;
    operand_mode_t dst;
  } decoded_t;

  typedef struct packed {
    word_t imm;
    word_t src;
    word_t dst_orig;
    word_t dst_addr;
  } operands_t;

  typedef struct packed {
    word_t addr;
    word_t data;
  } mem_write_t;

  typedef enum logic [2:0] {
    RESET_STAGE,
    FETCH_OP,
    FETCH_OPERANDS,
    EXECUTE,
    WRITE_MEM,
    HALT
  } stage_t;

  // order matters, the operand fetch skips forward by comparison
  typedef enum logic [2:0] {
    OF_IDLE,
    OF_SRC_IMM,
    OF_SRC_DATA,
    OF_DST_ADDR,
    OF_DST_DATA,
    OF_DONE
  } fetch_step_t;

endpackage

// File: hdl/exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
  input  logic                CLOCK,
  input  logic                RESET,
  input  logic                exec_strobe,
  input  cpu_pkg::decoded_t   decoded,
  input  cpu_pkg::operands_t  operands,
  output cpu_pkg::word_t      acc,
  output cpu_pkg::mem_write_t mem_write
);

  cpu_pkg::word_t result;
  logic           acc_write;
  logic           mem_dest;

  // **************************************************************************
  // ALU
  // **************************************************************************
  always_comb begin
    unique case (decoded.op)
      // wraps modulo 256
      cpu_pkg::ADD: result = operands.dst_orig + operands.src;
      cpu_pkg::MOV: result = operands.src;
      default:      result = operands.dst_orig;
    endcase
  end

  assign acc_write = exec_strobe && (decoded.dst == cpu_pkg::REG_A);
  assign mem_dest  = (decoded.dst == cpu_pkg::ADDR_REG_A) ||
                     (decoded.dst == cpu_pkg::ADDR_IMM);

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      acc <= '0;
    end else if (acc_write) begin
      acc <= result;
    end
  end

  // held for the two write cycles that follow
  always_ff @(posedge CLOCK) begin
    if (exec_strobe && mem_dest) begin
      mem_write.data <= result;
      if (decoded.dst == cpu_pkg::ADDR_REG_A) begin
        mem_write.addr <= acc;
      end else begin
        mem_write.addr <= operands.dst_addr;
      end
    end
  end

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module instr_decoder (
  input  logic              CLOCK,
  input  logic              RESET,
  input  logic              op_load,
  input  cpu_pkg::word_t    read_data,
  output cpu_pkg::decoded_t decoded
);

  function automatic cpu_pkg::operand_mode_t mode_of(logic [1:0] code);
    cpu_pkg::operand_mode_t mode;
    mode = cpu_pkg::UNUSED;
    case (code)
      `CPU_MODE_REG_A:      mode = cpu_pkg::REG_A;
      `CPU_MODE_ADDR_REG_A: mode = cpu_pkg::ADDR_REG_A;
      `CPU_MODE_ADDR_IMM:   mode = cpu_pkg::ADDR_IMM;
      `CPU_MODE_IMM:        mode = cpu_pkg::IMM;
    endcase
    return mode;
  endfunction

  function automatic cpu_pkg::decoded_t decode(cpu_pkg::word_t b);
    cpu_pkg::decoded_t d;
    d = '{op: cpu_pkg::HLT, src: cpu_pkg::UNUSED, dst: cpu_pkg::UNUSED};
    if (b == `CPU_NOP_OPCODE) begin
      d.op = cpu_pkg::NOP;
    end else if (b == `CPU_HLT_OPCODE) begin
      d.op = cpu_pkg::HLT;
    end else if (b[`CPU_OP_MSB:`CPU_OP_LSB] == `CPU_OP_MOV ||
                 b[`CPU_OP_MSB:`CPU_OP_LSB] == `CPU_OP_ADD) begin
      d.op  = (b[`CPU_OP_MSB:`CPU_OP_LSB] == `CPU_OP_ADD) ? cpu_pkg::ADD : cpu_pkg::MOV;
      d.src = mode_of(b[`CPU_SRC_MSB:`CPU_SRC_LSB]);
      d.dst = mode_of(b[`CPU_DST_MSB:`CPU_DST_LSB]);
    end else if (b[`CPU_OP_MSB:`CPU_OP_LSB] == `CPU_OP_JMP) begin
      // jump offset is always an immediate
      d.op  = cpu_pkg::JMP;
      d.src = cpu_pkg::IMM;
    end
    return d;
  endfunction

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      decoded <= decode(`CPU_NOP_OPCODE);
    end else if (op_load) begin
      decoded <= decode(read_data);
    end
  end

endmodule

// File: hdl/operand_fetch.sv
`timescale 1ns/10ps

module operand_fetch (
  input  logic               CLOCK,
  input  logic               RESET,
  input  logic               operand_start,
  input  cpu_pkg::decoded_t  decoded,
  input  cpu_pkg::word_t     ip,
  input  cpu_pkg::word_t     acc,
  input  cpu_pkg::word_t     read_data,
  output cpu_pkg::mem_req_t  operand_req,
  output cpu_pkg::word_t     ip_advance,
  output logic               operand_done,
  output cpu_pkg::operands_t operands
);

  cpu_pkg::fetch_step_t step;
  logic                 phase;
  // next instruction byte to consume
  cpu_pkg::word_t       ptr;

  // first step after s that the modes need
  function automatic cpu_pkg::fetch_step_t step_after(cpu_pkg::fetch_step_t s,
                                                      cpu_pkg::decoded_t d);
    cpu_pkg::fetch_step_t nxt;
    logic                 need_src_imm;
    logic                 need_src_data;
    logic                 need_dst_addr;
    logic                 need_dst_data;
    need_src_imm  = (d.src == cpu_pkg::IMM) || (d.src == cpu_pkg::ADDR_IMM);
    need_src_data = (d.src == cpu_pkg::ADDR_REG_A) || (d.src == cpu_pkg::ADDR_IMM);
    need_dst_addr = (d.dst == cpu_pkg::ADDR_IMM);
    need_dst_data = (d.dst == cpu_pkg::ADDR_REG_A) || (d.dst == cpu_pkg::ADDR_IMM);
    nxt = cpu_pkg::OF_DONE;
    if (need_dst_data && s < cpu_pkg::OF_DST_DATA) nxt = cpu_pkg::OF_DST_DATA;
    if (need_dst_addr && s < cpu_pkg::OF_DST_ADDR) nxt = cpu_pkg::OF_DST_ADDR;
    if (need_src_data && s < cpu_pkg::OF_SRC_DATA) nxt = cpu_pkg::OF_SRC_DATA;
    if (need_src_imm && s < cpu_pkg::OF_SRC_IMM) nxt = cpu_pkg::OF_SRC_IMM;
    return nxt;
  endfunction

  // **************************************************************************
  // read sequencing
  // **************************************************************************
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      step  <= cpu_pkg::OF_IDLE;
      phase <= 1'b0;
    end else begin
      case (step)
        cpu_pkg::OF_IDLE: begin
          phase <= 1'b0;
          if (operand_start) begin
            step <= step_after(cpu_pkg::OF_IDLE, decoded);
          end
        end
        cpu_pkg::OF_DONE: begin
          step <= cpu_pkg::OF_IDLE;
        end
        default: begin
          phase <= ~phase;
          if (phase) begin
            step <= step_after(step, decoded);
          end
        end
      endcase
    end
  end

  // data captured at the end of each read
  always_ff @(posedge CLOCK) begin
    if (operand_start) begin
      ptr               <= ip;
      operands.src      <= acc;
      operands.dst_orig <= acc;
    end else if (phase) begin
      case (step)
        cpu_pkg::OF_SRC_IMM: begin
          operands.imm <= read_data;
          if (decoded.src == cpu_pkg::IMM) begin
            operands.src <= read_data;
          end
          ptr <= ptr + 1'b1;
        end
        cpu_pkg::OF_SRC_DATA: operands.src <= read_data;
        cpu_pkg::OF_DST_ADDR: begin
          operands.dst_addr <= read_data;
          ptr               <= ptr + 1'b1;
        end
        cpu_pkg::OF_DST_DATA: operands.dst_orig <= read_data;
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    operand_req = '{cmd: cpu_pkg::MEM_READ, addr: ptr, wdata: '0};
    case (step)
      cpu_pkg::OF_SRC_DATA:
        operand_req.addr = (decoded.src == cpu_pkg::ADDR_REG_A) ? acc : operands.imm;
      cpu_pkg::OF_DST_DATA:
        operand_req.addr = (decoded.dst == cpu_pkg::ADDR_REG_A) ? acc : operands.dst_addr;
      cpu_pkg::OF_IDLE, cpu_pkg::OF_DONE:
        operand_req.cmd = cpu_pkg::MEM_IDLE;
      default: begin
      end
    endcase
  end

  assign ip_advance   = ptr;
  assign operand_done = (step == cpu_pkg::OF_DONE);

endmodule

// File: hdl/cpu_sequencer.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_sequencer (
  input  logic                CLOCK,
  input  logic                RESET,
  input  cpu_pkg::decoded_t   decoded,
  input  cpu_pkg::operands_t  operands,
  input  cpu_pkg::mem_req_t   operand_req,
  input  logic                operand_done,
  input  cpu_pkg::word_t      ip_advance,
  input  cpu_pkg::mem_write_t mem_write,
  output logic                op_load,
  output logic                operand_start,
  output logic                exec_strobe,
  output cpu_pkg::word_t      ip,
  output cpu_pkg::mem_req_t   mem_req,
  output logic                halted
);

  cpu_pkg::stage_t stage;
  // second cycle of a two-cycle access, or operands requested
  logic            phase;

  // **************************************************************************
  // stage machine and instruction pointer
  // **************************************************************************
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage <= cpu_pkg::RESET_STAGE;
      phase <= 1'b0;
      ip    <= `CPU_RESET_IP;
    end else begin
      unique case (stage)
        cpu_pkg::RESET_STAGE: begin
          stage <= cpu_pkg::FETCH_OP;
          phase <= 1'b0;
        end
        cpu_pkg::FETCH_OP: begin
          phase <= ~phase;
          if (phase) begin
            ip    <= ip + 1'b1;
            stage <= cpu_pkg::FETCH_OPERANDS;
          end
        end
        cpu_pkg::FETCH_OPERANDS: begin
          if (!phase) begin
            // decoded is valid here for the first time
            if (decoded.op == cpu_pkg::HLT) begin
              stage <= cpu_pkg::HALT;
            end else begin
              phase <= 1'b1;
            end
          end else if (operand_done) begin
            ip    <= ip_advance;
            phase <= 1'b0;
            stage <= cpu_pkg::EXECUTE;
          end
        end
        cpu_pkg::EXECUTE: begin
          // relative to the byte after the immediate
          if (decoded.op == cpu_pkg::JMP) begin
            ip <= ip + operands.imm;
          end
          if (decoded.dst == cpu_pkg::ADDR_REG_A || decoded.dst == cpu_pkg::ADDR_IMM) begin
            stage <= cpu_pkg::WRITE_MEM;
          end else begin
            stage <= cpu_pkg::FETCH_OP;
          end
        end
        cpu_pkg::WRITE_MEM: begin
          phase <= ~phase;
          if (phase) begin
            stage <= cpu_pkg::FETCH_OP;
          end
        end
        default: begin
          stage <= cpu_pkg::HALT;
        end
      endcase
    end
  end

  assign op_load       = (stage == cpu_pkg::FETCH_OP) && phase;
  assign operand_start = (stage == cpu_pkg::FETCH_OPERANDS) && !phase &&
                         (decoded.op != cpu_pkg::HLT);
  assign exec_strobe   = (stage == cpu_pkg::EXECUTE);
  assign halted        = (stage == cpu_pkg::HALT);

  // bus owner by stage
  always_comb begin
    unique case (stage)
      cpu_pkg::FETCH_OP:
        mem_req = '{cmd: cpu_pkg::MEM_READ, addr: ip, wdata: '0};
      cpu_pkg::FETCH_OPERANDS:
        mem_req = operand_req;
      cpu_pkg::WRITE_MEM:
        mem_req = '{cmd: cpu_pkg::MEM_WRITE, addr: mem_write.addr, wdata: mem_write.data};
      default:
        mem_req = '{cmd: cpu_pkg::MEM_IDLE, addr: ip, wdata: '0};
    endcase
  end

endmodule

// File: hdl/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
  input  logic             CLOCK,
  input  logic             RESET,
  input  cpu_pkg::word_t   read_data,
  output cpu_pkg::mem_req_t mem_req,
  output cpu_pkg::word_t   acc_out,
  output logic             halted
);

  cpu_pkg::decoded_t   decoded;
  cpu_pkg::operands_t  operands;
  cpu_pkg::mem_req_t   operand_req;
  cpu_pkg::mem_write_t mem_write;
  cpu_pkg::word_t      ip;
  cpu_pkg::word_t      ip_advance;
  cpu_pkg::word_t      acc;
  logic                op_load;
  logic                operand_start;
  logic                operand_done;
  logic                exec_strobe;

  cpu_sequencer sequencer_i (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .decoded       (decoded),
    .operands      (operands),
    .operand_req   (operand_req),
    .operand_done  (operand_done),
    .ip_advance    (ip_advance),
    .mem_write     (mem_write),
    .op_load       (op_load),
    .operand_start (operand_start),
    .exec_strobe   (exec_strobe),
    .ip            (ip),
    .mem_req       (mem_req),
    .halted        (halted)
  );

  instr_decoder decoder_i (
    .CLOCK     (CLOCK),
    .RESET     (RESET),
    .op_load   (op_load),
    .read_data (read_data),
    .decoded   (decoded)
  );

  operand_fetch operand_fetch_i (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .operand_start (operand_start),
    .decoded       (decoded),
    .ip            (ip),
    .acc           (acc),
    .read_data     (read_data),
    .operand_req   (operand_req),
    .ip_advance    (ip_advance),
    .operand_done  (operand_done),
    .operands      (operands)
  );

  exec_unit exec_unit_i (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .exec_strobe (exec_strobe),
    .decoded     (decoded),
    .operands    (operands),
    .acc         (acc),
    .mem_write   (mem_write)
  );

  assign acc_out = acc;

endmodule

// File: verif/cpu_checker.sv
`timescale 1ns/10ps

module cpu_checker (
  input logic              CLOCK,
  input logic              RESET,
  input cpu_pkg::mem_req_t mem_req,
  input logic              halted
);

  // failed assertions so far
  int   violations = 0;
  // set on the second cycle of a bus access
  logic second_beat;

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      second_beat <= 1'b0;
    end else if (mem_req.cmd != cpu_pkg::MEM_IDLE) begin
      second_beat <= ~second_beat;
    end else begin
      second_beat <= 1'b0;
    end
  end

  // **************************************************************************
  // halt and bus properties
  // **************************************************************************
  halt_sticky: assert property (@(posedge CLOCK) disable iff (RESET)
    halted |=> halted)
    else begin
      $error("halted fell without a reset");
      violations++;
    end

  no_write_halted: assert property (@(posedge CLOCK) disable iff (RESET)
    halted |-> (mem_req.cmd != cpu_pkg::MEM_WRITE))
    else begin
      $error("memory write issued while halted");
      violations++;
    end

  // command, address and write data held for the second cycle
  access_held: assert property (@(posedge CLOCK) disable iff (RESET)
    (mem_req.cmd != cpu_pkg::MEM_IDLE && !second_beat) |=> $stable(mem_req))
    else begin
      $error("bus access not held for two cycles");
      violations++;
    end

endmodule

bind cpu_top cpu_checker checker_i (
  .CLOCK   (CLOCK),
  .RESET   (RESET),
  .mem_req (mem_req),
  .halted  (halted)
);

// File: verif/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_tb;

  localparam int NUM_TESTS    = 6;
  localparam int HALT_TIMEOUT = 2000;

  // code at 0x00-0x0F and data at 0x10-0x1F, lowest address in the top byte
  typedef struct packed {
    logic [127:0]   code;
    logic [127:0]   data;
    cpu_pkg::word_t acc;
    logic           check_mem;
    cpu_pkg::word_t mem_addr;
    cpu_pkg::word_t mem_byte;
  } test_entry_t;

  logic              CLOCK = 1'b0;
  logic              RESET;
  cpu_pkg::word_t    read_data = '0;
  cpu_pkg::mem_req_t mem_req;
  cpu_pkg::word_t    acc_out;
  logic              halted;

  cpu_pkg::word_t    mem [256];
  test_entry_t       tests [NUM_TESTS];
  string             names [NUM_TESTS];
  int                errors;
  int                failed_tests;

  cpu_top dut_i (
    .CLOCK     (CLOCK),
    .RESET     (RESET),
    .read_data (read_data),
    .mem_req   (mem_req),
    .acc_out   (acc_out),
    .halted    (halted)
  );

  always #5 CLOCK = ~CLOCK;

  // **************************************************************************
  // memory model, zero latency, read data refreshed just after each edge
  // **************************************************************************
  always @(posedge CLOCK) begin
    if (mem_req.cmd == cpu_pkg::MEM_WRITE) begin
      mem[mem_req.addr] = mem_req.wdata;
    end
    #1;
    read_data = mem[mem_req.addr];
  end

  // opcode = op << 4 | dst << 2 | src, FE is NOP and FF is HLT
  task automatic fill_table();
    // 0xC8 + 0x5A wraps to 0x22, then + 0x10
    names[0] = "imm_add_wrap";
    tests[0] = '{code: 128'h03C8_135A_1310_FFFF_FFFF_FFFF_FFFF_FFFF, data: 128'h0,
                 acc: 8'h32, check_mem: 1'b0, mem_addr: 8'h00, mem_byte: 8'h00};
    // A = [0x14] = 0x17, then A += [A] = [0x17] = 0x25
    names[1] = "mem_sources";
    tests[1] = '{code: 128'h0214_11FF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF,
                 data: 128'h0000_0000_1700_0025_0000_0000_0000_0000,
                 acc: 8'h3C, check_mem: 1'b0, mem_addr: 8'h00, mem_byte: 8'h00};
    // [0x18] = 0x44, [0x18] += 5, then [A=0x12] = 0x21 + [0x18]
    names[2] = "mem_dest";
    tests[2] = '{code: 128'h0312_0B44_181B_0518_1618_FFFF_FFFF_FFFF,
                 data: 128'h0000_2100_0000_0000_9900_0000_0000_0000,
                 acc: 8'h12, check_mem: 1'b1, mem_addr: 8'h12, mem_byte: 8'h6A};
    // jump at 0x02 lands on 0x04 + 4, skipping two adds of 0x40
    names[3] = "jump_skip";
    tests[3] = '{code: 128'h0307_C004_1340_1340_1301_FFFF_FFFF_FFFF, data: 128'h0,
                 acc: 8'h08, check_mem: 1'b0, mem_addr: 8'h00, mem_byte: 8'h00};
    // 0x50 has no defined operation
    names[4] = "undefined_halt";
    tests[4] = '{code: 128'h035C_1301_5013_20FF_FFFF_FFFF_FFFF_FFFF, data: 128'h0,
                 acc: 8'h5D, check_mem: 1'b0, mem_addr: 8'h00, mem_byte: 8'h00};
    // accumulator starts from zero again after the new reset
    names[5] = "nop_fresh_reset";
    tests[5] = '{code: 128'hFEFE_FE13_09FE_FFFF_FFFF_FFFF_FFFF_FFFF, data: 128'h0,
                 acc: 8'h09, check_mem: 1'b0, mem_addr: 8'h00, mem_byte: 8'h00};
  endtask

  task automatic load_image(input test_entry_t t);
    for (int a = 0; a < 256; a++) begin
      if (a < 16) begin
        mem[a] = t.code[127 - 8 * a -: 8];
      end else if (a < 32) begin
        mem[a] = t.data[127 - 8 * (a - 16) -: 8];
      end else begin
        mem[a] = $urandom;
      end
    end
  endtask

  task automatic reset_core(input test_entry_t t);
    @(posedge CLOCK);
    #1;
    RESET = 1'b1;
    load_image(t);
    repeat (4) @(posedge CLOCK);
    #1;
    RESET = 1'b0;
  endtask

  task automatic wait_halted(output bit done);
    done = 1'b0;
    for (int n = 0; n < HALT_TIMEOUT && !done; n++) begin
      @(posedge CLOCK);
      #1;
      done = halted;
    end
  endtask

  task automatic compare_word(input string name, input cpu_pkg::word_t expected,
                              input cpu_pkg::word_t actual);
    if (actual !== expected) begin
      $display("** Error %s: accumulator expected 0x%02h, actual 0x%02h",
               name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_mem(input string name, input cpu_pkg::word_t addr,
                             input cpu_pkg::word_t expected, input cpu_pkg::word_t actual);
    if (actual !== expected) begin
      $display("** Error %s: memory[0x%02h] expected 0x%02h, actual 0x%02h",
               name, addr, expected, actual);
      errors++;
    end
  endtask

  initial begin
    bit done;
    int errors_before;
    RESET = 1'b1;
    errors = 0;
    failed_tests = 0;
    void'($urandom(74654));
    fill_table();
    for (int i = 0; i < NUM_TESTS; i++) begin
      errors_before = errors;
      reset_core(tests[i]);
      wait_halted(done);
      if (!done) begin
        $display("%s: core never halted within %0d cycles", names[i], HALT_TIMEOUT);
        errors++;
      end else begin
        compare_word(names[i], tests[i].acc, acc_out);
        if (tests[i].check_mem) begin
          compare_mem(names[i], tests[i].mem_addr, tests[i].mem_byte, mem[tests[i].mem_addr]);
        end
      end
      if (errors == errors_before) begin
        $display("%s: passed", names[i]);
      end else begin
        $display("%s: failed", names[i]);
        failed_tests++;
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d assertion failures", NUM_TESTS,
             NUM_TESTS - failed_tests, failed_tests, dut_i.checker_i.violations);
    if (failed_tests == 0 && dut_i.checker_i.violations == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+include
hdl/cpu_pkg.sv
hdl/exec_unit.sv
hdl/instr_decoder.sv
hdl/operand_fetch.sv
hdl/cpu_sequencer.sv
hdl/cpu_top.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the accumulator CPU testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cpu_tb \
  -f list.f \
  -o cpu_sim

# keep running after an assertion error so the testbench can report it
./obj_dir/cpu_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
